//--- bench/dma_tb.sv
/* directed tests for the DMA subsystem with a DRAM model and an SPI slave model
   test regions in DRAM stay apart, untouched words hold an address-based fill */
`timescale 1ns/1ps

module dma_tb
    import dma_pkg::*;
();

    // worst word is an SPI word, two bytes of about 19 cycles plus a DRAM access
    localparam int MAX_WORDS         = 100;
    localparam int WORST_WORD_CYCLES = 50;
    localparam int TIMEOUT_CYCLES    = 4 * MAX_WORDS * WORST_WORD_CYCLES;
    localparam int MEM_WORDS         = 1 << DRAM_AW;

    logic        clk;
    logic        rst_n;
    logic        zio_wr;
    logic [15:0] zaddr;
    zbyte_t      zdata;
    logic        dma_act;
    logic        dma_zwt;
    dram_addr_t  mem_addr;
    logic        mem_we;
    dram_word_t  mem_wdata;
    dram_word_t  mem_rdata;
    logic        sck;
    logic        mosi;
    logic        miso;
    pal_addr_t   pal_addr;
    dram_word_t  pal_data;
    pal_addr_t   spr_addr;
    dram_word_t  spr_data;

    dram_word_t  mem [0:MEM_WORDS-1];
    dram_addr_t  write_log [$];   // every DRAM write address, in order
    dram_addr_t  exp_addr [$];
    dram_word_t  exp_word [$];
    zbyte_t      miso_bytes [$];  // slave reply stream
    zbyte_t      mosi_log [$];    // bytes the master sent
    zbyte_t      spi_tx;
    zbyte_t      spi_rx;
    int          spi_bits;
    logic [15:0] lfsr;
    int          cycles;
    int          word_errors;
    int          addr_errors;
    int          byte_errors;
    int          other_errors;

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dma_subsys uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .zio_wr    (zio_wr),
        .zaddr     (zaddr),
        .zdata     (zdata),
        .dma_act   (dma_act),
        .dma_zwt   (dma_zwt),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .sck       (sck),
        .mosi      (mosi),
        .miso      (miso),
        .pal_addr  (pal_addr),
        .pal_data  (pal_data),
        .spr_addr  (spr_addr),
        .spr_data  (spr_data)
    );

    // word memory, read data one cycle after the address
    always @(posedge clk)
    begin
        if (mem_we === 1'b1)
        begin
            mem[mem_addr] <= mem_wdata;
            write_log.push_back(mem_addr);
        end
        mem_rdata <= mem[mem_addr];
    end

    // SPI slave, mode 0, MSB first
    assign miso = spi_tx[7];

    always @(posedge sck)
    begin
        spi_rx = {spi_rx[6:0], mosi};
        spi_bits = spi_bits + 1;
        if (spi_bits == 8)
        begin
            mosi_log.push_back(spi_rx);
            spi_bits = 0;
        end
    end

    always @(negedge sck)
    begin
        if (spi_bits == 0)
            spi_tx = pop_miso();          // byte done, next reply byte
        else
            spi_tx = {spi_tx[6:0], 1'b1};
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles, dma_act is %b",
                     TIMEOUT_CYCLES, dma_act);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic dram_word_t fill_word(dram_addr_t a);
        return a[15:0] ^ {a[20:16], a[20:16], a[20:16], 1'b1};
    endfunction

    // Galois LFSR, x^16+x^14+x^13+x^11+1, one step per bit
    function automatic dram_word_t rand_bits(int n);
        dram_word_t v;
        int         i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic zbyte_t pop_miso();
        if (miso_bytes.size() > 0)
            return miso_bytes.pop_front();
        return 8'hFF;                     // idle line
    endfunction

    task automatic check_word(string what, dram_word_t got, dram_word_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_addr(string what, dram_addr_t got, dram_addr_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            addr_errors++;
        end
    endtask

    task automatic check_byte(string what, zbyte_t got, zbyte_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            byte_errors++;
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            other_errors++;
        end
    endtask

    // one Z80 I/O write, held for one clock
    task automatic cpu_out(zbyte_t reg_idx, zbyte_t value);
        @(posedge clk);
        #1;
        zio_wr = 1'b1;
        zaddr  = {reg_idx, DMA_PORT_LO};
        zdata  = value;
        @(posedge clk);
        #1;
        zio_wr = 1'b0;
    endtask

    // registers take byte addresses
    task automatic set_src(dram_addr_t a);
        cpu_out(REG_SADDRL, {a[6:0], 1'b0});
        cpu_out(REG_SADDRH, {2'b00, a[12:7]});
        cpu_out(REG_SADDRX, a[20:13]);
    endtask

    task automatic set_dst(dram_addr_t a);
        cpu_out(REG_DADDRL, {a[6:0], 1'b0});
        cpu_out(REG_DADDRH, {2'b00, a[12:7]});
        cpu_out(REG_DADDRX, a[20:13]);
    endtask

    task automatic set_burst(int words, int bursts);
        cpu_out(REG_LEN, zbyte_t'(words - 1));
        cpu_out(REG_NUM, zbyte_t'(bursts - 1));
    endtask

    task automatic launch(zbyte_t ctrl);
        cpu_out(REG_CTRL, ctrl);
    endtask

    task automatic wait_done();
        if (dma_act !== 1'b1)
        begin
            $display("transfer did not start after the control write at %0t", $time);
            other_errors++;
        end
        while (dma_act === 1'b1)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic clear_logs();
        write_log.delete();
        exp_addr.delete();
        exp_word.delete();
        mosi_log.delete();
        miso_bytes.delete();
    endtask

    task automatic prime_spi();
        spi_bits = 0;
        spi_tx   = pop_miso();
    endtask

    // source words in DRAM and where each one must land
    task automatic stage_copy(dram_addr_t sbase, dram_addr_t dbase,
                              int words, int bursts, int step);
        dram_word_t w;
        int         b;
        int         i;
        for (b = 0; b < bursts; b++)
        begin
            for (i = 0; i < words; i++)
            begin
                w = rand_bits(16);
                mem[sbase + b * step + i] = w;
                exp_addr.push_back(dram_addr_t'(dbase + b * step + i));
                exp_word.push_back(w);
            end
        end
    endtask

    task automatic check_dest(string tag);
        int i;
        if (write_log.size() != exp_addr.size())
        begin
            $display("%s: %0d DRAM writes seen where %0d were expected",
                     tag, write_log.size(), exp_addr.size());
            other_errors++;
        end
        for (i = 0; i < exp_addr.size(); i++)
        begin
            if (i < write_log.size())
                check_addr({tag, " write address"}, write_log[i], exp_addr[i]);
            check_word({tag, " word"}, mem[exp_addr[i]], exp_word[i]);
        end
    endtask

    task automatic read_palette(pal_addr_t ca, pal_addr_t sa,
                                output dram_word_t cw, output dram_word_t sw);
        pal_addr = ca;
        spr_addr = sa;
        @(posedge clk);
        #1;
        cw = pal_data;
        sw = spr_data;
    endtask

    task automatic reset_state_test();
        if (dma_act !== 1'b0 || sck !== 1'b0 || mem_we !== 1'b0)
        begin
            $display("ERROR at %0t: not idle after reset, dma_act %b sck %b mem_we %b",
                     $time, dma_act, sck, mem_we);
            other_errors++;
        end
    endtask

    task automatic ram_copy_test();
        clear_logs();
        stage_copy(21'h00100, 21'h00400, 4, 3, 4);
        set_src(21'h00100);
        set_dst(21'h00400);
        set_burst(4, 3);
        launch({1'b0, 4'b0000, DEV_RAM});
        check_flag("wait flag", dma_zwt, 1'b0);
        wait_done();
        check_dest("ram copy");
    endtask

    task automatic aligned_test(logic asz);
        dram_addr_t sbase;
        dram_addr_t dbase;
        int         step;
        sbase = asz ? 21'h03090 : 21'h01010;
        dbase = asz ? 21'h040A4 : 21'h020A0;
        step  = asz ? 256 : 128;          // words, 512 or 256 bytes
        clear_logs();
        stage_copy(sbase, dbase, 4, 3, step);
        set_src(sbase);
        set_dst(dbase);
        set_burst(4, 3);
        launch({1'b0, 1'b0, 1'b1, 1'b1, asz, DEV_RAM});
        wait_done();
        check_dest(asz ? "aligned 512" : "aligned 256");
    endtask

    task automatic spi_to_ram_test();
        zbyte_t lo;
        zbyte_t hi;
        int     i;
        clear_logs();
        for (i = 0; i < 8; i++)
        begin
            lo = zbyte_t'(rand_bits(8));
            hi = zbyte_t'(rand_bits(8));
            miso_bytes.push_back(lo);
            miso_bytes.push_back(hi);
            exp_addr.push_back(dram_addr_t'(21'h05000 + i));
            exp_word.push_back({hi, lo});   // first byte is the low one
        end
        prime_spi();
        set_dst(21'h05000);
        set_burst(4, 2);
        launch({1'b0, 4'b0000, DEV_SPI});
        wait_done();
        check_dest("spi to ram");
        if (mosi_log.size() != 16)
        begin
            $display("spi to ram: %0d bytes sent on mosi instead of 16", mosi_log.size());
            other_errors++;
        end
        for (i = 0; i < mosi_log.size(); i++)
            check_byte("spi to ram mosi byte", mosi_log[i], 8'hFF);
    endtask

    task automatic ram_to_spi_test();
        dram_word_t w;
        int         i;
        clear_logs();
        for (i = 0; i < 6; i++)
        begin
            w = rand_bits(16);
            mem[21'h06000 + i] = w;
            exp_word.push_back(w);
        end
        prime_spi();
        set_src(21'h06000);
        set_burst(2, 3);
        launch({1'b1, 1'b1, 3'b000, DEV_SPI});   // wait flag set this time
        check_flag("wait flag", dma_zwt, 1'b1);
        wait_done();
        if (mosi_log.size() != 12)
        begin
            $display("ram to spi: %0d bytes sent on mosi instead of 12", mosi_log.size());
            other_errors++;
        end
        for (i = 0; i < 6 && 2 * i + 1 < mosi_log.size(); i++)
        begin
            w = exp_word[i];
            check_byte("ram to spi low byte", mosi_log[2 * i], w[7:0]);
            check_byte("ram to spi high byte", mosi_log[2 * i + 1], w[15:8]);
        end
        if (write_log.size() != 0)
        begin
            $display("ram to spi: DRAM was written %0d times", write_log.size());
            other_errors++;
        end
    endtask

    task automatic palette_test();
        dram_word_t cram_ref [0:7];
        dram_word_t cram_w;
        dram_word_t sfile_w;
        dram_word_t w;
        int         i;
        clear_logs();
        for (i = 0; i < 8; i++)
        begin
            cram_ref[i] = rand_bits(16);
            mem[21'h07000 + i] = cram_ref[i];
        end
        set_src(21'h07000);
        set_dst(21'h00040);               // CRAM index 40h
        set_burst(8, 1);
        launch({1'b1, 4'b0000, DEV_CRAM});
        wait_done();
        for (i = 0; i < 8; i++)
        begin
            w = rand_bits(16);
            mem[21'h07100 + i] = w;
            exp_word.push_back(w);
        end
        set_src(21'h07100);
        set_dst(21'h00080);               // SFILE index 80h
        launch({1'b1, 4'b0000, DEV_SFILE});
        wait_done();
        if (write_log.size() != 0)
        begin
            $display("palette: DRAM was written %0d times", write_log.size());
            other_errors++;
        end
        for (i = 0; i < 8; i++)
        begin
            read_palette(pal_addr_t'(8'h40 + i), pal_addr_t'(8'h80 + i), cram_w, sfile_w);
            check_word("cram word", cram_w, cram_ref[i]);
            check_word("sfile word", sfile_w, exp_word[i]);
        end
        // CRAM cannot be a source, so this must not touch it
        set_dst(21'h00040);
        launch({1'b0, 4'b0000, DEV_CRAM});
        wait_done();
        for (i = 0; i < 8; i++)
        begin
            read_palette(pal_addr_t'(8'h40 + i), pal_addr_t'(8'h80 + i), cram_w, sfile_w);
            check_word("cram word after direction 0", cram_w, cram_ref[i]);
        end
    endtask

    task automatic lockout_test();
        clear_logs();
        stage_copy(21'h08000, 21'h09000, 4, 2, 4);
        set_src(21'h08000);
        set_dst(21'h09000);
        set_burst(4, 2);
        launch({1'b0, 4'b0000, DEV_RAM});
        set_dst(21'h0A000);               // lands mid transfer
        cpu_out(REG_LEN, 8'd0);
        if (dma_act !== 1'b1)
        begin
            $display("lockout: transfer ended before the register writes were issued");
            other_errors++;
        end
        wait_done();
        check_dest("lockout");
    endtask

    initial
    begin
        int a;
        zio_wr       = 1'b0;
        zaddr        = '0;
        zdata        = '0;
        pal_addr     = '0;
        spr_addr     = '0;
        mem_rdata    = '0;
        spi_tx       = 8'hFF;
        spi_rx       = '0;
        spi_bits     = 0;
        lfsr         = 16'd34;
        cycles       = 0;
        word_errors  = 0;
        addr_errors  = 0;
        byte_errors  = 0;
        other_errors = 0;
        for (a = 0; a < MEM_WORDS; a++)
            mem[a] = fill_word(dram_addr_t'(a));

        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        reset_state_test();
        ram_copy_test();
        aligned_test(1'b0);
        aligned_test(1'b1);
        spi_to_ram_test();
        ram_to_spi_test();
        palette_test();
        lockout_test();

        $display("summary: %0d word errors, %0d address errors, %0d byte errors, %0d other",
                 word_errors, addr_errors, byte_errors, other_errors);
        if (word_errors + addr_errors + byte_errors + other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
/* free-running 20 ns clock, reset held low for the first 5 rising edges */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;   // release just after the edge
    end

endmodule

//--- build.f
hdl/dma_pkg.sv
hdl/dma_port_decode.sv
hdl/dma_engine.sv
hdl/dram_port.sv
hdl/spi_xfer.sv
hdl/palette_ram.sv
hdl/dma_subsys.sv
bench/tb_clock.sv
bench/dma_tb.sv

//--- hdl/dma_engine.sv
/* DMA engine: RAM-RAM, SPI<->RAM and RAM->CRAM/SFILE word transfers
   register writes are ignored while dma_act is high
   IDE and read-back from CRAM/SFILE are inert: their device phase ends at once */
`timescale 1ns/1ps

module dma_engine
    import dma_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [NUM_STB-1:0] dmaport_wr,
    input  zbyte_t             zdata,
    input  dram_word_t         dram_rddata,
    input  logic               dram_next,
    input  zbyte_t             spi_rddata,
    input  logic               spi_stb,
    output logic               dma_act,
    output logic               dma_zwt,
    output dram_addr_t         dram_addr,
    output dram_word_t         dram_wrdata,
    output logic               dram_req,
    output logic               dram_rnw,
    output zbyte_t             spi_wrdata,
    output logic               spi_req,
    output dram_word_t         data,
    output pal_addr_t          wraddr,
    output logic               cram_we,
    output logic               sfile_we
);

    logic [NUM_STB-1:0] dma_wr;
    dev_t       device;
    logic       dma_wnr;     // 0 device to RAM, 1 RAM to device
    logic       dma_salgn;
    logic       dma_dalgn;
    logic       dma_asz;     // aligned step, 0 is 256 bytes, 1 is 512
    logic       phase;       // 0 read, 1 write
    logic       bsel;        // SPI byte, 0 low first
    zbyte_t     b_len;
    zbyte_t     b_num;
    zbyte_t     b_ctr;
    logic [8:0] n_ctr;       // top bit set when idle
    dram_addr_t s_addr;
    dram_addr_t d_addr;
    zbyte_t     s_lo;        // saved low word address for aligned reload
    zbyte_t     d_lo;
    logic dv_ram, dv_spi, dv_crm, dv_sfl, dv_none;
    logic state_rd, state_wr, state_mem, state_dev, dev_req;
    logic dev_stb, phase_end, cyc_end, next_burst, byte_switch;

    // next word address, linear or aligned to a 128/256 word block
    function automatic dram_addr_t step_addr(dram_addr_t cur, zbyte_t base_lo,
                                             logic algn, logic asz, logic nb);
        logic [8:0]  inc_l;
        zbyte_t      nxt_l;
        logic [1:0]  add_h;
        logic [13:0] nxt_h;
        logic        mid;
        inc_l = {1'b0, cur[7:0]} + 9'd1;
        nxt_l = (algn && nb) ? base_lo : inc_l[7:0];
        add_h = algn ? {nb && asz, nb && !asz} : {inc_l[8], 1'b0};
        nxt_h = cur[20:7] + {12'd0, add_h};
        mid   = algn ? (asz ? nxt_l[7] : nxt_h[0]) : inc_l[7];
        return {nxt_h[13:1], mid, nxt_l[6:0]};
    endfunction

    assign dma_wr = dmaport_wr & {NUM_STB{!dma_act}};
    assign dma_act = !n_ctr[8];

    always_comb
    begin
        dv_ram  = 1'b0;
        dv_spi  = 1'b0;
        dv_crm  = 1'b0;
        dv_sfl  = 1'b0;
        dv_none = 1'b0;
        case (device)
            DEV_RAM:   dv_ram = 1'b1;
            DEV_SPI:   dv_spi = 1'b1;
            DEV_CRAM:  {dv_crm, dv_none} = {dma_wnr, !dma_wnr};  // write only
            DEV_SFILE: {dv_sfl, dv_none} = {dma_wnr, !dma_wnr};
            DEV_IDE:   dv_none = 1'b1;
            default:   dv_none = 1'b1;
        endcase
    end

    assign state_rd  = !phase;
    assign state_wr  = phase;
    assign state_mem = dv_ram || (dma_wnr ^ phase);
    assign state_dev = !state_mem;
    assign dev_req   = dma_act && state_dev;

    assign dev_stb     = cram_we || sfile_we || (spi_stb && bsel) || (dev_req && dv_none);
    assign phase_end   = (state_mem && dram_next) || (state_dev && dev_stb);
    assign cyc_end     = phase && phase_end;
    assign next_burst  = (b_ctr == 8'd0);
    assign byte_switch = dv_spi && spi_stb;

    // control byte and phase tracking
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            {dma_wnr, dma_zwt, dma_salgn, dma_dalgn, dma_asz} <= '0;
            device <= '0;
            phase  <= 1'b0;
            bsel   <= 1'b0;
        end
        else if (dma_wr[STB_LAUNCH])
        begin
            {dma_wnr, dma_zwt, dma_salgn, dma_dalgn, dma_asz} <= zdata[7:3];
            device <= zdata[2:0];
            phase  <= 1'b0;
            bsel   <= 1'b0;
        end
        else
        begin
            if (phase_end)
                phase <= !phase;
            if (byte_switch)
                bsel <= !bsel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            n_ctr <= 9'h100;
            b_ctr <= '0;
        end
        else if (dma_wr[STB_LAUNCH])
        begin
            n_ctr <= {1'b0, b_num};
            b_ctr <= b_len;
        end
        else if (cyc_end)
        begin
            n_ctr <= n_ctr - {8'd0, next_burst};   // wraps to idle after last burst
            b_ctr <= next_burst ? b_len : b_ctr - 8'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dma_wr[STB_LEN])
            b_len <= zdata;
        if (dma_wr[STB_NUM])
            b_num <= zdata;
    end

    // CPU gives byte addresses, registers keep word addresses
    always_ff @(posedge clk)
    begin
        if (phase_end && state_rd)
            s_addr <= step_addr(s_addr, s_lo, dma_salgn, dma_asz, next_burst);
        else
        begin
            if (dma_wr[STB_SADDRL])
                {s_addr[6:0], s_lo[6:0]} <= {zdata[7:1], zdata[7:1]};
            if (dma_wr[STB_SADDRH])
                {s_addr[12:7], s_lo[7]} <= {zdata[5:0], zdata[0]};
            if (dma_wr[STB_SADDRX])
                s_addr[20:13] <= zdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (phase_end && state_wr)
            d_addr <= step_addr(d_addr, d_lo, dma_dalgn, dma_asz, next_burst);
        else
        begin
            if (dma_wr[STB_DADDRL])
                {d_addr[6:0], d_lo[6:0]} <= {zdata[7:1], zdata[7:1]};
            if (dma_wr[STB_DADDRH])
                {d_addr[12:7], d_lo[7]} <= {zdata[5:0], zdata[0]};
            if (dma_wr[STB_DADDRX])
                d_addr[20:13] <= zdata;
        end
    end

    // word buffer, filled on read phases
    always_ff @(posedge clk)
    begin
        if (state_rd)
        begin
            if (dram_next)
                data <= dram_rddata;
            else if (spi_stb)
            begin
                if (bsel)
                    data[15:8] <= spi_rddata;
                else
                    data[7:0] <= spi_rddata;
            end
        end
    end

    assign dram_addr   = state_rd ? s_addr : d_addr;
    assign dram_wrdata = data;
    assign dram_req    = dma_act && state_mem;
    assign dram_rnw    = state_rd;

    assign spi_wrdata = {8{state_rd}} | (bsel ? data[15:8] : data[7:0]);  // FF on reads
    assign spi_req    = dev_req && dv_spi && !spi_stb;

    assign wraddr   = d_addr[7:0];
    assign cram_we  = dev_req && dv_crm && state_wr;
    assign sfile_we = dev_req && dv_sfl && state_wr;

    a_req_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(dram_req && spi_req));

    a_cram_dir: assert property (@(posedge clk) disable iff (!rst_n)
        cram_we |-> dma_wnr);

endmodule

//--- hdl/dma_pkg.sv
/* shared types and constants for the DMA subsystem
   register indices are the upper I/O address byte, all at low byte AF hex */
package dma_pkg;

    localparam int DRAM_AW = 21;   // word address, 4 MB of 16-bit words
    localparam int WORD_W  = 16;
    localparam int NUM_STB = 9;

    typedef logic [DRAM_AW-1:0] dram_addr_t;
    typedef logic [WORD_W-1:0]  dram_word_t;
    typedef logic [7:0]         zbyte_t;
    typedef logic [7:0]         pal_addr_t;
    typedef logic [2:0]         dev_t;

    // device codes from the control byte
    localparam dev_t DEV_RAM   = 3'b001;
    localparam dev_t DEV_SPI   = 3'b010;
    localparam dev_t DEV_IDE   = 3'b011;  // no controller behind it
    localparam dev_t DEV_CRAM  = 3'b100;
    localparam dev_t DEV_SFILE = 3'b101;

    localparam zbyte_t DMA_PORT_LO = 8'hAF;

    localparam zbyte_t REG_SADDRL = 8'h1A;
    localparam zbyte_t REG_SADDRH = 8'h1B;
    localparam zbyte_t REG_SADDRX = 8'h1C;
    localparam zbyte_t REG_DADDRL = 8'h1D;
    localparam zbyte_t REG_DADDRH = 8'h1E;
    localparam zbyte_t REG_DADDRX = 8'h1F;
    localparam zbyte_t REG_LEN    = 8'h26;
    localparam zbyte_t REG_CTRL   = 8'h27;
    localparam zbyte_t REG_NUM    = 8'h28;

    // bit positions in the strobe vector
    localparam int STB_SADDRL = 0;
    localparam int STB_SADDRH = 1;
    localparam int STB_SADDRX = 2;
    localparam int STB_DADDRL = 3;
    localparam int STB_DADDRH = 4;
    localparam int STB_DADDRX = 5;
    localparam int STB_LEN    = 6;
    localparam int STB_LAUNCH = 7;
    localparam int STB_NUM    = 8;

    typedef enum logic [1:0] {MEM_IDLE, MEM_ACCESS, MEM_DONE} mem_state_t;

endpackage

//--- hdl/dma_port_decode.sv
/* Z80 I/O write decode for the DMA registers
   strobes come out in the same cycle as zio_wr so they line up with zdata */
`timescale 1ns/1ps

module dma_port_decode
    import dma_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               zio_wr,
    input  logic [15:0]        zaddr,
    output logic [NUM_STB-1:0] dmaport_wr
);

    logic port_hit;

    assign port_hit = zio_wr && (zaddr[7:0] == DMA_PORT_LO);

    always_comb
    begin
        dmaport_wr = '0;
        if (port_hit)
        begin
            case (zaddr[15:8])
                REG_SADDRL: dmaport_wr[STB_SADDRL] = 1'b1;
                REG_SADDRH: dmaport_wr[STB_SADDRH] = 1'b1;
                REG_SADDRX: dmaport_wr[STB_SADDRX] = 1'b1;
                REG_DADDRL: dmaport_wr[STB_DADDRL] = 1'b1;
                REG_DADDRH: dmaport_wr[STB_DADDRH] = 1'b1;
                REG_DADDRX: dmaport_wr[STB_DADDRX] = 1'b1;
                REG_LEN:    dmaport_wr[STB_LEN]    = 1'b1;
                REG_CTRL:   dmaport_wr[STB_LAUNCH] = 1'b1;
                REG_NUM:    dmaport_wr[STB_NUM]    = 1'b1;
                default:    dmaport_wr = '0;   // other ports on AF
            endcase
        end
    end

    // one register per write, and only while the CPU is writing
    a_stb_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(dmaport_wr) && ((dmaport_wr == '0) || zio_wr));

endmodule

//--- hdl/dma_subsys.sv
/* DMA subsystem top; DRAM is external on the mem_* port
   dma_zwt is only presented, the CPU is not stalled here */
`timescale 1ns/1ps

module dma_subsys
    import dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        zio_wr,
    input  logic [15:0] zaddr,
    input  zbyte_t      zdata,
    output logic        dma_act,
    output logic        dma_zwt,
    output dram_addr_t  mem_addr,
    output logic        mem_we,
    output dram_word_t  mem_wdata,
    input  dram_word_t  mem_rdata,
    output logic        sck,
    output logic        mosi,
    input  logic        miso,
    input  pal_addr_t   pal_addr,
    output dram_word_t  pal_data,
    input  pal_addr_t   spr_addr,
    output dram_word_t  spr_data
);

    logic [NUM_STB-1:0] dmaport_wr;
    dram_addr_t dram_addr;
    dram_word_t dram_wrdata;
    dram_word_t dram_rddata;
    logic       dram_req;
    logic       dram_rnw;
    logic       dram_next;
    zbyte_t     spi_wrdata;
    zbyte_t     spi_rddata;
    logic       spi_req;
    logic       spi_stb;
    dram_word_t wr_data;        // word buffer to palette
    pal_addr_t  wraddr;
    logic       cram_we;
    logic       sfile_we;

    dma_port_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .zio_wr     (zio_wr),
        .zaddr      (zaddr),
        .dmaport_wr (dmaport_wr)
    );

    dma_engine u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .dmaport_wr  (dmaport_wr),
        .zdata       (zdata),
        .dram_rddata (dram_rddata),
        .dram_next   (dram_next),
        .spi_rddata  (spi_rddata),
        .spi_stb     (spi_stb),
        .dma_act     (dma_act),
        .dma_zwt     (dma_zwt),
        .dram_addr   (dram_addr),
        .dram_wrdata (dram_wrdata),
        .dram_req    (dram_req),
        .dram_rnw    (dram_rnw),
        .spi_wrdata  (spi_wrdata),
        .spi_req     (spi_req),
        .data        (wr_data),
        .wraddr      (wraddr),
        .cram_we     (cram_we),
        .sfile_we    (sfile_we)
    );

    dram_port u_dram (
        .clk         (clk),
        .rst_n       (rst_n),
        .dram_req    (dram_req),
        .dram_rnw    (dram_rnw),
        .dram_addr   (dram_addr),
        .dram_wrdata (dram_wrdata),
        .dram_rddata (dram_rddata),
        .dram_next   (dram_next),
        .mem_addr    (mem_addr),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

    spi_xfer u_spi (
        .clk        (clk),
        .rst_n      (rst_n),
        .spi_req    (spi_req),
        .spi_wrdata (spi_wrdata),
        .spi_rddata (spi_rddata),
        .spi_stb    (spi_stb),
        .sck        (sck),
        .mosi       (mosi),
        .miso       (miso)
    );

    palette_ram u_pal (
        .clk      (clk),
        .cram_we  (cram_we),
        .sfile_we (sfile_we),
        .wraddr   (wraddr),
        .data     (wr_data),
        .pal_addr (pal_addr),
        .pal_data (pal_data),
        .spr_addr (spr_addr),
        .spr_data (spr_data)
    );

endmodule

//--- hdl/dram_port.sv
/* one access per request on a synchronous word memory, 3 cycles each
   memory must return the read word in the cycle after the address */
`timescale 1ns/1ps

module dram_port
    import dma_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dram_req,
    input  logic       dram_rnw,
    input  dram_addr_t dram_addr,
    input  dram_word_t dram_wrdata,
    output dram_word_t dram_rddata,
    output logic       dram_next,
    output dram_addr_t mem_addr,
    output logic       mem_we,
    output dram_word_t mem_wdata,
    input  dram_word_t mem_rdata
);

    mem_state_t state;
    logic       start;

    assign start = (state == MEM_IDLE) && dram_req;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state  <= MEM_IDLE;
            mem_we <= 1'b0;
        end
        else
        begin
            case (state)
                MEM_IDLE:
                    if (dram_req)
                    begin
                        state  <= MEM_ACCESS;
                        mem_we <= !dram_rnw;
                    end
                MEM_ACCESS:
                begin
                    state  <= MEM_DONE;
                    mem_we <= 1'b0;
                end
                default: state <= MEM_IDLE;   // MEM_DONE
            endcase
        end
    end

    // address and write word held from access through done
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            mem_addr  <= dram_addr;
            mem_wdata <= dram_wrdata;
        end
    end

    assign dram_next   = (state == MEM_DONE);
    assign dram_rddata = mem_rdata;

    a_we_write: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_we) |-> $past(!dram_rnw && dram_req));

endmodule

//--- hdl/palette_ram.sv
/* CRAM and SFILE, 256 words each, written only by the DMA
   read ports have one cycle of latency */
`timescale 1ns/1ps

module palette_ram
    import dma_pkg::*;
(
    input  logic       clk,
    input  logic       cram_we,
    input  logic       sfile_we,
    input  pal_addr_t  wraddr,
    input  dram_word_t data,
    input  pal_addr_t  pal_addr,
    output dram_word_t pal_data,
    input  pal_addr_t  spr_addr,
    output dram_word_t spr_data
);

    dram_word_t cram  [0:255];
    dram_word_t sfile [0:255];

    always_ff @(posedge clk)
    begin
        if (cram_we)
            cram[wraddr] <= data;
        pal_data <= cram[pal_addr];     // video side
    end

    always_ff @(posedge clk)
    begin
        if (sfile_we)
            sfile[wraddr] <= data;
        spr_data <= sfile[spr_addr];    // sprite side
    end

endmodule

//--- hdl/spi_xfer.sv
/* byte SPI master, mode 0, MSB first, sck at clk/2
   spi_req must be low in the spi_stb cycle or a new byte starts */
`timescale 1ns/1ps

module spi_xfer
    import dma_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   spi_req,
    input  zbyte_t spi_wrdata,
    output zbyte_t spi_rddata,
    output logic   spi_stb,
    output logic   sck,
    output logic   mosi,
    input  logic   miso
);

    logic       busy;
    logic [2:0] bit_cnt;
    zbyte_t     sreg;       // tx out the top, rx in the bottom
    logic       miso_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            spi_stb <= 1'b0;
        end
        else
        begin
            spi_stb <= 1'b0;
            if (!busy)
                busy <= spi_req;
            else if (!sck)
                sck <= 1'b1;
            else
            begin
                sck     <= 1'b0;
                bit_cnt <= bit_cnt + 3'd1;   // wraps to 0 for the next byte
                if (bit_cnt == 3'd7)
                begin
                    busy    <= 1'b0;
                    spi_stb <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && spi_req)
            sreg <= spi_wrdata;
        else if (busy && !sck)
            miso_q <= miso;                  // sample at sck rise
        else if (busy)
            sreg <= {sreg[6:0], miso_q};     // shift at sck fall
    end

    assign mosi       = sreg[7];
    assign spi_rddata = sreg;

endmodule
